// File: compile.f
isa_pkg.sv
pipe_pkg.sv
decode_ctrl.sv
reg_file.sv
exec_alu.sv
core_pipe.sv
core_pipe_checker.sv
core_pipe_monitor.sv
tb_core_pipe.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f compile.f --top-module tb_core_pipe -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || echo "Build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1

// File: tb_core_pipe.sv
// Pipeline testbench
`timescale 1ns/100ps
module tb_core_pipe;
   import isa_pkg::*;

   localparam int N_ENT   = 25;
   localparam int RST_CYC = 16;
   // At most three cycles per entry plus slack for the flush
   localparam int TMO_CYC = 4 * N_ENT + RST_CYC;

   logic                gclk;
   logic                grst;
   logic                dena;
   logic [XLEN-1:0]     ich_dat;
   logic [31:2]         rpc_if;
   logic                irq;
   logic                exc_ill;
   logic                wb_en;
   logic [REG_AW-1:0]   wb_rd;
   logic [XLEN-1:0]     wb_dat;
   logic                bra_taken;
   logic [XLEN-1:0]     bra_tgt;
   logic                hzd_bpc;

   // Expected response travels alongside the stimulus
   logic                exp_vld;
   int                  exp_idx;
   logic [XLEN-1:0]     exp_ins;
   logic                exp_wen;
   logic [REG_AW-1:0]   exp_rd;
   logic [XLEN-1:0]     exp_dat;
   logic                exp_bt;
   logic [XLEN-1:0]     exp_tgt;
   logic                exp_hzd;
   int                  err_cnt;
   int                  chk_cnt;

   // Stimulus table
   logic [XLEN-1:0]     t_ins  [N_ENT];
   logic [XLEN-1:0]     t_pc   [N_ENT];
   logic                t_irq  [N_ENT];
   logic                t_exc  [N_ENT];
   logic                t_dena [N_ENT];
   logic                t_wen  [N_ENT];
   logic [REG_AW-1:0]   t_rd   [N_ENT];
   logic [XLEN-1:0]     t_dat  [N_ENT];
   logic                t_bt   [N_ENT];
   logic [XLEN-1:0]     t_tgt  [N_ENT];
   logic                t_hzd  [N_ENT];

   int                  seed;
   int                  gap;
   int                  cyc;
   int                  i;

   core_pipe dut0 (.*);
   core_pipe_monitor mon0 (.*);

   // Register format word
   function automatic logic [XLEN-1:0] enc_a(input logic [5:0] opc, input logic [4:0] rd,
                                             input logic [4:0] ra, input logic [4:0] rb);
      insn_u w;
      w.a.opc  = opc;
      w.a.rd   = rd;
      w.a.ra   = ra;
      w.a.rb   = rb;
      w.a.func = '0;
      return w;
   endfunction

   // Immediate format word
   function automatic logic [XLEN-1:0] enc_b(input logic [5:0] opc, input logic [4:0] rd,
                                             input logic [4:0] ra, input logic [15:0] imm);
      insn_u w;
      w.b.opc = opc;
      w.b.rd  = rd;
      w.b.ra  = ra;
      w.b.imm = imm;
      return w;
   endfunction

   // Fill one row with PCs one word apart from 0x100
   task automatic put(input int n, input logic [31:0] ins, input logic irq_v,
                      input logic exc_v, input logic wen, input logic [4:0] rd,
                      input logic [31:0] dat, input logic bt, input logic [31:0] tgt);
      t_ins[n]  = ins;
      t_pc[n]   = 32'h100 + 4 * n;
      t_irq[n]  = irq_v;
      t_exc[n]  = exc_v;
      t_dena[n] = 1'b1;
      t_wen[n]  = wen;
      t_rd[n]   = rd;
      t_dat[n]  = dat;
      t_bt[n]   = bt;
      t_tgt[n]  = tgt;
      t_hzd[n]  = 1'b0;
   endtask

   task automatic build_table;
      // Arithmetic, logic, forwarding and write-through
      put(0, enc_b(OPC_ADDI, 1, 0, 16'h0005), 0, 0, 1, 1, 32'h5, 0, 0);
      put(1, enc_b(OPC_ADDI, 2, 0, 16'hfffd), 0, 0, 1, 2, 32'hffff_fffd, 0, 0);
      put(2, enc_a(OPC_ADD, 3, 1, 2), 0, 0, 1, 3, 32'h2, 0, 0);
      put(3, enc_a(OPC_RSUB, 4, 3, 1), 0, 0, 1, 4, 32'h3, 0, 0);
      put(4, enc_a(OPC_OR, 5, 4, 1), 0, 0, 1, 5, 32'h7, 0, 0);
      put(5, enc_a(OPC_AND, 6, 5, 4), 0, 0, 1, 6, 32'h3, 0, 0);
      put(6, enc_a(OPC_XOR, 7, 6, 5), 0, 0, 1, 7, 32'h4, 0, 0);
      put(7, enc_b(OPC_RSUBI, 8, 7, 16'd10), 0, 0, 1, 8, 32'h6, 0, 0);
      // Prefix with irq held off on the next word
      put(8, enc_b(OPC_IMM, 0, 0, 16'h1234), 0, 0, 0, 0, 32'h0, 0, 0);
      put(9, enc_b(OPC_ADDI, 9, 0, 16'h5678), 1, 0, 1, 9, 32'h1234_5678, 0, 0);
      put(10, enc_b(OPC_ADDI, 10, 9, 16'h8000), 0, 0, 1, 10, 32'h1233_d678, 0, 0);
      // Branch-link with delay slot, then without
      put(11, enc_b(OPC_BRUI, 15, 5'b10100, 16'h0040), 0, 0, 1, 15, 32'h12c, 1, 32'h16c);
      put(12, enc_b(OPC_ADDI, 11, 0, 16'h0001), 0, 0, 1, 11, 32'h1, 0, 0);
      put(13, enc_b(OPC_BRUI, 16, 5'b00100, 16'h0020), 0, 0, 1, 16, 32'h134, 1, 32'h154);
      put(14, enc_b(OPC_ADDI, 12, 0, 16'h0007), 0, 0, 0, 0, 32'h0, 0, 0);
      // Conditional branches with delay slot except the last
      put(15, enc_b(OPC_BCCI, 5'b10000, 0, 16'h0010), 0, 0, 0, 0, 32'h0, 1, 32'h14c);
      put(16, enc_b(OPC_BCCI, 5'b10001, 1, 16'h0008), 0, 0, 0, 0, 32'h0, 1, 32'h148);
      put(17, enc_b(OPC_BCCI, 5'b10000, 1, 16'h0004), 0, 0, 0, 0, 32'h0, 0, 0);
      put(18, enc_a(OPC_BCC, 5'b00001, 0, 0), 0, 0, 0, 0, 32'h0, 0, 0);
      // Interrupt and illegal instruction traps
      put(19, enc_b(OPC_ADDI, 13, 0, 16'h0003), 1, 0, 1, 14, 32'h14c, 1, 32'h10);
      put(20, enc_b(OPC_ADDI, 12, 0, 16'h0009), 0, 0, 0, 0, 32'h0, 0, 0);
      put(21, enc_a(OPC_XOR, 20, 1, 1), 0, 1, 1, 17, 32'h154, 1, 32'h20);
      put(22, enc_b(OPC_ADDI, 12, 0, 16'h0002), 0, 0, 0, 0, 32'h0, 0, 0);
      put(23, enc_a(OPC_ADD, 18, 14, 17), 0, 0, 1, 18, 32'h2a0, 0, 0);
      put(24, enc_b(OPC_ADDI, 19, 18, 16'h0001), 0, 0, 1, 19, 32'h2a1, 0, 0);
      // Taken branches without a delay slot squash the next word
      t_hzd[13] = 1'b1;
      t_hzd[19] = 1'b1;
      t_hzd[21] = 1'b1;
   endtask

   initial begin
      gclk = 1'b0;
      forever #50 gclk = ~gclk;
   end

   // Run limit
   initial begin
      cyc = 0;
      while (cyc < TMO_CYC) begin
         @(posedge gclk);
         cyc = cyc + 1;
      end
      $display("Timeout after %0d cycles, %0d of %0d entries checked", cyc, chk_cnt, N_ENT);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      seed    = 32'hb2fe;
      grst    = 1'b1;
      dena    = 1'b1;
      ich_dat = '0;
      rpc_if  = '0;
      irq     = 1'b0;
      exc_ill = 1'b0;
      exp_vld = 1'b0;
      exp_idx = 0;
      exp_ins = '0;
      exp_wen = 1'b0;
      exp_rd  = '0;
      exp_dat = '0;
      exp_bt  = 1'b0;
      exp_tgt = '0;
      exp_hzd = 1'b0;
      build_table();
      repeat (RST_CYC) @(posedge gclk);
      grst <= 1'b0;
      for (i = 0; i < N_ENT; i++) begin
         @(posedge gclk);
         ich_dat <= t_ins[i];
         rpc_if  <= t_pc[i][31:2];
         irq     <= t_irq[i];
         exc_ill <= t_exc[i];
         exp_vld <= 1'b1;
         exp_idx <= i;
         exp_ins <= t_ins[i];
         exp_wen <= t_wen[i];
         exp_rd  <= t_rd[i];
         exp_dat <= t_dat[i];
         exp_bt  <= t_bt[i];
         exp_tgt <= t_tgt[i];
         exp_hzd <= t_hzd[i];
         // Random stall of up to two cycles before the entry is taken
         gap = {$random(seed)} % 3;
         if (gap != 0) begin
            dena <= 1'b0;
            repeat (gap) @(posedge gclk);
         end
         dena <= t_dena[i];
      end
      // Idle words flush the last entries
      @(posedge gclk);
      ich_dat <= '0;
      irq     <= 1'b0;
      exc_ill <= 1'b0;
      exp_vld <= 1'b0;
      dena    <= 1'b1;
      wait (chk_cnt == N_ENT);
      @(negedge gclk);
      $display("Checked %0d entries, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: core_pipe_monitor.sv
// Pipeline response monitor
`timescale 1ns/100ps
module core_pipe_monitor (
   input  logic                        gclk,
   input  logic                        grst,
   input  logic                        dena,
   input  logic                        wb_en,
   input  logic [isa_pkg::REG_AW-1:0]  wb_rd,
   input  logic [isa_pkg::XLEN-1:0]    wb_dat,
   input  logic                        bra_taken,
   input  logic [isa_pkg::XLEN-1:0]    bra_tgt,
   input  logic                        hzd_bpc,
   input  logic                        exp_vld,
   input  int                          exp_idx,
   input  logic [isa_pkg::XLEN-1:0]    exp_ins,
   input  logic                        exp_wen,
   input  logic [isa_pkg::REG_AW-1:0]  exp_rd,
   input  logic [isa_pkg::XLEN-1:0]    exp_dat,
   input  logic                        exp_bt,
   input  logic [isa_pkg::XLEN-1:0]    exp_tgt,
   input  logic                        exp_hzd,
   output int                          err_cnt,
   output int                          chk_cnt
);
   import isa_pkg::*;

   // Stage 1 is in execute, stage 2 in writeback
   logic              s1_vld, s2_vld;
   int                s1_idx, s2_idx;
   insn_u             s1_ins, s2_ins;
   logic              s1_wen, s2_wen;
   logic [REG_AW-1:0] s1_rd, s2_rd;
   logic [XLEN-1:0]   s1_dat, s2_dat;
   logic              s1_bt;
   logic [XLEN-1:0]   s1_tgt;
   logic              s1_hzd;
   int                edge_cnt;
   int                seen_cnt;
   int                ent_err [64];

   task automatic report_err(input string name, input int idx, input logic [31:0] got,
                             input logic [31:0] exp);
      $display("ERR %0t entry %0d %s got %h exp %h", $time, idx, name, got, exp);
      err_cnt = err_cnt + 1;
      ent_err[idx] = ent_err[idx] + 1;
   endtask

   // Follow entries through the enabled edges only
   always @(posedge gclk) begin
      if (grst) begin
         s1_vld   <= 1'b0;
         s2_vld   <= 1'b0;
         edge_cnt <= 0;
      end else if (dena) begin
         s1_vld   <= exp_vld;
         s1_idx   <= exp_idx;
         s1_ins   <= exp_ins;
         s1_wen   <= exp_wen;
         s1_rd    <= exp_rd;
         s1_dat   <= exp_dat;
         s1_bt    <= exp_bt;
         s1_tgt   <= exp_tgt;
         s1_hzd   <= exp_hzd;
         s2_vld   <= s1_vld;
         s2_idx   <= s1_idx;
         s2_ins   <= s1_ins;
         s2_wen   <= s1_wen;
         s2_rd    <= s1_rd;
         s2_dat   <= s1_dat;
         edge_cnt <= edge_cnt + 1;
      end
   end

   // Compare mid-cycle on each enabled edge
   always @(negedge gclk) begin
      if (grst) begin
         err_cnt  = 0;
         chk_cnt  = 0;
         seen_cnt = 0;
         for (int n = 0; n < 64; n++)
            ent_err[n] = 0;
      end else if (edge_cnt != seen_cnt) begin
         seen_cnt = edge_cnt;
         if (s1_vld) begin
            if (bra_taken !== s1_bt)
               report_err("bra_taken", s1_idx, {31'b0, bra_taken}, {31'b0, s1_bt});
            else if (s1_bt && bra_tgt !== s1_tgt)
               report_err("bra_tgt", s1_idx, bra_tgt, s1_tgt);
            if (hzd_bpc !== s1_hzd)
               report_err("hzd_bpc", s1_idx, {31'b0, hzd_bpc}, {31'b0, s1_hzd});
         end
         if (s2_vld) begin
            if (wb_en !== s2_wen)
               report_err("wb_en", s2_idx, {31'b0, wb_en}, {31'b0, s2_wen});
            else if (s2_wen && wb_rd !== s2_rd)
               report_err("wb_rd", s2_idx, {27'b0, wb_rd}, {27'b0, s2_rd});
            else if (s2_wen && wb_dat !== s2_dat)
               report_err("wb_dat", s2_idx, wb_dat, s2_dat);
            // One line per retired entry
            $display("entry %0d opc %o %s", s2_idx, s2_ins.a.opc,
                     (ent_err[s2_idx] == 0) ? "ok" : "mismatch");
            chk_cnt = chk_cnt + 1;
         end
      end
   end

endmodule

// File: core_pipe_checker.sv
// Pipeline output assertions
`timescale 1ns/100ps
module core_pipe_checker (
   input logic                        gclk,
   input logic                        grst,
   input logic                        dena,
   input logic                        wb_en,
   input logic [isa_pkg::REG_AW-1:0]  wb_rd,
   input logic [isa_pkg::XLEN-1:0]    wb_dat,
   input logic                        bra_taken,
   input logic                        hzd_bpc
);
   // r0 is never a writeback target
   a_no_r0: assert property (@(posedge gclk) disable iff (grst) wb_en |-> wb_rd != '0)
      else $error("write to r0 retired");

   // Writeback quiet once reset has been seen
   a_rst_quiet: assert property (@(posedge gclk) $past(grst) |-> !wb_en)
      else $error("wb_en high during reset");

   // A stalled edge changes no output
   a_hold: assert property (@(posedge gclk) disable iff (grst)
      (!$past(dena) && !$past(grst)) |->
         ($stable(wb_en) && $stable(wb_rd) && $stable(wb_dat) &&
          $stable(bra_taken) && $stable(hzd_bpc)))
      else $error("outputs moved while dena low");

endmodule

bind core_pipe core_pipe_checker chk0 (
   .gclk(gclk), .grst(grst), .dena(dena), .wb_en(wb_en), .wb_rd(wb_rd),
   .wb_dat(wb_dat), .bra_taken(bra_taken), .hzd_bpc(hzd_bpc)
);

// File: core_pipe.sv
// Decode and execute pipeline top
`timescale 1ns/100ps
module core_pipe (
   input  logic                        gclk,
   input  logic                        grst,
   input  logic                        dena,
   input  logic [isa_pkg::XLEN-1:0]    ich_dat,
   input  logic [31:2]                 rpc_if,
   input  logic                        irq,
   input  logic                        exc_ill,
   output logic                        wb_en,
   output logic [isa_pkg::REG_AW-1:0]  wb_rd,
   output logic [isa_pkg::XLEN-1:0]    wb_dat,
   output logic                        bra_taken,
   output logic [isa_pkg::XLEN-1:0]    bra_tgt,
   output logic                        hzd_bpc
);
   import isa_pkg::*;
   import pipe_pkg::*;

   // Register file ports
   logic [REG_AW-1:0] ra_if, rb_if, rd_if;
   logic [XLEN-1:0]   opa_if, opb_if, opd_if;

   // Decode to execute
   logic [XLEN-1:0]   opa_of, opb_of, opd_of;
   logic [AF_W-1:0]   alu_of;
   logic [SEL_W-1:0]  sel_of;
   logic [REG_AW-1:0] rd_of;
   logic [BRC_W-1:0]  brc_of;

   // Execute back to decode
   logic [XLEN-1:0]   alu_ex;
   logic [REG_AW-1:0] rd_ex;
   logic              fwd_ex;
   logic [BRA_W-1:0]  bra_ex;

   decode_ctrl u_dec (
      .gclk, .grst, .dena, .ich_dat, .rpc_if, .irq, .exc_ill,
      .opa_if, .opb_if, .opd_if, .alu_ex, .rd_ex, .fwd_ex, .bra_ex,
      .ra_if, .rb_if, .rd_if, .opa_of, .opb_of, .opd_of,
      .alu_of, .sel_of, .rd_of, .brc_of, .hzd_bpc
   );

   reg_file u_rf (
      .gclk, .grst, .ra_if, .rb_if, .rd_if,
      .wb_en, .wb_rd, .wb_dat, .opa_if, .opb_if, .opd_if
   );

   exec_alu u_exe (
      .gclk, .grst, .dena, .opa_of, .opb_of, .opd_of,
      .alu_of, .sel_of, .rd_of, .brc_of,
      .alu_ex, .rd_ex, .fwd_ex, .bra_ex, .bra_taken, .bra_tgt,
      .wb_en, .wb_rd, .wb_dat
   );

endmodule

// File: exec_alu.sv
// Execute stage and writeback register
`timescale 1ns/100ps
module exec_alu (
   input  logic                          gclk,
   input  logic                          grst,
   input  logic                          dena,
   input  logic [isa_pkg::XLEN-1:0]      opa_of,
   input  logic [isa_pkg::XLEN-1:0]      opb_of,
   input  logic [isa_pkg::XLEN-1:0]      opd_of,
   input  logic [pipe_pkg::AF_W-1:0]     alu_of,
   input  logic [pipe_pkg::SEL_W-1:0]    sel_of,
   input  logic [isa_pkg::REG_AW-1:0]    rd_of,
   input  logic [pipe_pkg::BRC_W-1:0]    brc_of,
   output logic [isa_pkg::XLEN-1:0]      alu_ex,
   output logic [isa_pkg::REG_AW-1:0]    rd_ex,
   output logic                          fwd_ex,
   output logic [pipe_pkg::BRA_W-1:0]    bra_ex,
   output logic                          bra_taken,
   output logic [isa_pkg::XLEN-1:0]      bra_tgt,
   output logic                          wb_en,
   output logic [isa_pkg::REG_AW-1:0]    wb_rd,
   output logic [isa_pkg::XLEN-1:0]      wb_dat
);
   import isa_pkg::*;
   import pipe_pkg::*;

   logic [XLEN-1:0] sum_ab;
   logic [XLEN-1:0] alu_r;
   logic            taken;

   always_comb begin
      // Shared adder, also the branch target
      sum_ab = opa_of + opb_of;

      case (alu_of)
         AF_ADD:  alu_r = sum_ab;
         AF_RSUB: alu_r = opb_of - opa_of;
         AF_AND:  alu_r = opa_of & opb_of;
         AF_OR:   alu_r = opa_of | opb_of;
         AF_XOR:  alu_r = opa_of ^ opb_of;
         AF_PASS: alu_r = opb_of;
         default: alu_r = opb_of;
      endcase

      // Conditions test opd against zero
      case (brc_of[1:0])
         BRK_ALW: taken = 1'b1;
         BRK_BEQ: taken = (opd_of == '0);
         BRK_BNE: taken = (opd_of != '0);
         default: taken = 1'b0;
      endcase
   end

   // Link writes the branch PC carried in opd
   assign alu_ex = (sel_of == SEL_RPC) ? opd_of : alu_r;

   // Forwarding view of the instruction in execute
   assign rd_ex  = rd_of;
   assign fwd_ex = (sel_of != SEL_NOP) && (rd_of != '0);

   assign bra_ex    = {taken, brc_of[BRC_DLY_BIT]};
   assign bra_taken = taken;
   assign bra_tgt   = sum_ab;

   always_ff @(posedge gclk) begin
      if (grst) begin
         wb_en <= 1'b0;
      end else if (dena) begin
         wb_en <= fwd_ex;
      end
   end

   // Retired destination and value
   always_ff @(posedge gclk) begin
      if (dena) begin
         wb_rd  <= rd_of;
         wb_dat <= alu_ex;
      end
   end

endmodule

// File: reg_file.sv
// General purpose register file
`timescale 1ns/100ps
module reg_file (
   input  logic                        gclk,
   input  logic                        grst,
   input  logic [isa_pkg::REG_AW-1:0]  ra_if,
   input  logic [isa_pkg::REG_AW-1:0]  rb_if,
   input  logic [isa_pkg::REG_AW-1:0]  rd_if,
   input  logic                        wb_en,
   input  logic [isa_pkg::REG_AW-1:0]  wb_rd,
   input  logic [isa_pkg::XLEN-1:0]    wb_dat,
   output logic [isa_pkg::XLEN-1:0]    opa_if,
   output logic [isa_pkg::XLEN-1:0]    opb_if,
   output logic [isa_pkg::XLEN-1:0]    opd_if
);
   import isa_pkg::*;

   logic [XLEN-1:0] regs [NUM_REGS];

   // One read port, r0 hardwired, writeback bypassed
   function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
      logic [XLEN-1:0] val;
      if (addr == '0)
         val = '0;
      else if (wb_en && addr == wb_rd)
         val = wb_dat;
      else
         val = regs[addr];
      return val;
   endfunction

   always_comb begin
      opa_if = read_port(ra_if);
      opb_if = read_port(rb_if);
      opd_if = read_port(rd_if);
   end

   // Writes blocked during reset, r0 never stored
   always_ff @(posedge gclk) begin
      if (!grst && wb_en && wb_rd != '0) begin
         regs[wb_rd] <= wb_dat;
      end
   end

endmodule

// File: decode_ctrl.sv
// Instruction decode and operand fetch
`timescale 1ns/100ps
module decode_ctrl (
   input  logic                          gclk,
   input  logic                          grst,
   input  logic                          dena,
   input  logic [isa_pkg::XLEN-1:0]      ich_dat,
   input  logic [31:2]                   rpc_if,
   input  logic                          irq,
   input  logic                          exc_ill,
   input  logic [isa_pkg::XLEN-1:0]      opa_if,
   input  logic [isa_pkg::XLEN-1:0]      opb_if,
   input  logic [isa_pkg::XLEN-1:0]      opd_if,
   input  logic [isa_pkg::XLEN-1:0]      alu_ex,
   input  logic [isa_pkg::REG_AW-1:0]    rd_ex,
   input  logic                          fwd_ex,
   input  logic [pipe_pkg::BRA_W-1:0]    bra_ex,
   output logic [isa_pkg::REG_AW-1:0]    ra_if,
   output logic [isa_pkg::REG_AW-1:0]    rb_if,
   output logic [isa_pkg::REG_AW-1:0]    rd_if,
   output logic [isa_pkg::XLEN-1:0]      opa_of,
   output logic [isa_pkg::XLEN-1:0]      opb_of,
   output logic [isa_pkg::XLEN-1:0]      opd_of,
   output logic [pipe_pkg::AF_W-1:0]     alu_of,
   output logic [pipe_pkg::SEL_W-1:0]    sel_of,
   output logic [isa_pkg::REG_AW-1:0]    rd_of,
   output logic [pipe_pkg::BRC_W-1:0]    brc_of,
   output logic                          hzd_bpc
);
   import isa_pkg::*;
   import pipe_pkg::*;

   insn_u             ins;
   logic              inj_xce;
   logic              inj_int;
   logic              imm_prev;
   logic [15:0]       imm_hi;
   logic [XLEN-1:0]   imm_val;
   logic [XLEN-1:0]   pc_val;
   logic [XLEN-1:0]   ra_val;
   logic [XLEN-1:0]   rb_val;
   logic [XLEN-1:0]   rd_val;
   logic              is_add;
   logic              is_rsub;
   logic              is_log;
   logic              is_imm;
   logic              is_bru;
   logic              is_bcc;
   logic [XLEN-1:0]   opa_n;
   logic [XLEN-1:0]   opb_n;
   logic [XLEN-1:0]   opd_n;
   logic [AF_W-1:0]   alu_n;
   logic [SEL_W-1:0]  sel_n;
   logic [BRC_W-1:0]  brc_n;

   // Taken branch without delay slot kills the word in decode
   assign hzd_bpc = bra_ex[BRA_TKN] & ~bra_ex[BRA_DLY];

   // Trap injection, exception wins over interrupt
   assign inj_xce = exc_ill & ~hzd_bpc;
   // No interrupt between IMM and its consumer
   assign inj_int = irq & ~imm_prev & ~hzd_bpc;

   assign ins = inj_xce ? INSN_XCE :
                inj_int ? INSN_INT :
                ich_dat;

   // Register file addresses straight from the word
   assign ra_if = ins.a.ra;
   assign rb_if = ins.a.rb;
   assign rd_if = ins.a.rd;

   always_comb begin
      // Opcode groups
      is_add  = (ins.a.opc == OPC_ADD)  | (ins.a.opc == OPC_ADDI);
      is_rsub = (ins.a.opc == OPC_RSUB) | (ins.a.opc == OPC_RSUBI);
      is_log  = (ins.a.opc == OPC_OR) | (ins.a.opc == OPC_AND) | (ins.a.opc == OPC_XOR);
      is_imm  = (ins.a.opc == OPC_IMM);
      is_bru  = (ins.a.opc == OPC_BRU)  | (ins.a.opc == OPC_BRUI);
      is_bcc  = (ins.a.opc == OPC_BCC)  | (ins.a.opc == OPC_BCCI);

      // Upper half from a pending prefix, else sign extension
      imm_val[15:0]  = ins.b.imm;
      imm_val[31:16] = (imm_prev & ~inj_xce) ? imm_hi : {16{ins.b.imm[15]}};

      pc_val = {rpc_if, 2'b00};

      // Bypass the instruction now in execute
      ra_val = (fwd_ex && ins.a.ra == rd_ex) ? alu_ex : opa_if;
      rb_val = (fwd_ex && ins.a.rb == rd_ex) ? alu_ex : opb_if;
      rd_val = (fwd_ex && ins.a.rd == rd_ex) ? alu_ex : opd_if;

      // Branches add their offset to the PC, or to zero when absolute
      if (is_bru && ins.a.ra[BRU_ABS_BIT])
         opa_n = '0;
      else if (is_bru || is_bcc)
         opa_n = pc_val;
      else
         opa_n = ra_val;

      opb_n = ins.a.opc[OPC_IFORM] ? imm_val : rb_val;

      // Link value for BRU, tested register for BCC
      if (is_bru)
         opd_n = pc_val;
      else if (is_bcc)
         opd_n = ra_val;
      else
         opd_n = rd_val;

      unique case (ins.a.opc)
         OPC_ADD, OPC_ADDI:   alu_n = AF_ADD;
         OPC_RSUB, OPC_RSUBI: alu_n = AF_RSUB;
         OPC_AND:             alu_n = AF_AND;
         OPC_OR:              alu_n = AF_OR;
         OPC_XOR:             alu_n = AF_XOR;
         default:             alu_n = AF_PASS;
      endcase

      // Squashed slot becomes a no-op
      if (hzd_bpc)
         sel_n = SEL_NOP;
      else if (is_add || is_rsub || is_log)
         sel_n = SEL_ALU;
      else if (is_bru && ins.a.ra[BRU_LNK_BIT])
         sel_n = SEL_RPC;
      else
         sel_n = SEL_NOP;

      if (hzd_bpc)
         brc_n = {1'b0, BRK_NONE};
      else if (is_bru)
         brc_n = {ins.a.ra[BRU_DLY_BIT], BRK_ALW};
      else if (is_bcc)
         brc_n = {ins.a.rd[BCC_DLY_BIT], ins.a.rd[BCC_NE_BIT] ? BRK_BNE : BRK_BEQ};
      else
         brc_n = {1'b0, BRK_NONE};
   end

   // Control half of the decode register
   always_ff @(posedge gclk) begin
      if (grst) begin
         sel_of   <= SEL_NOP;
         brc_of   <= {1'b0, BRK_NONE};
         alu_of   <= AF_PASS;
         rd_of    <= '0;
         imm_prev <= 1'b0;
      end else if (dena) begin
         sel_of   <= sel_n;
         brc_of   <= brc_n;
         alu_of   <= alu_n;
         rd_of    <= ins.a.rd;
         // Prefix lives for exactly one following word
         imm_prev <= is_imm & ~hzd_bpc;
      end
   end

   // Operand and prefix payload
   always_ff @(posedge gclk) begin
      if (dena) begin
         opa_of <= opa_n;
         opb_of <= opb_n;
         opd_of <= opd_n;
         imm_hi <= ins.b.imm;
      end
   end

endmodule

// File: pipe_pkg.sv
// Pipeline control codes
package pipe_pkg;

   // What execute writes back
   localparam int SEL_W = 3;
   localparam logic [SEL_W-1:0] SEL_NOP = 3'd0;
   localparam logic [SEL_W-1:0] SEL_ALU = 3'd1;
   localparam logic [SEL_W-1:0] SEL_RPC = 3'd2;

   // ALU function
   localparam int AF_W = 3;
   localparam logic [AF_W-1:0] AF_ADD  = 3'd0;
   localparam logic [AF_W-1:0] AF_RSUB = 3'd1;
   localparam logic [AF_W-1:0] AF_AND  = 3'd2;
   localparam logic [AF_W-1:0] AF_OR   = 3'd3;
   localparam logic [AF_W-1:0] AF_XOR  = 3'd4;
   localparam logic [AF_W-1:0] AF_PASS = 3'd5;

   // Branch kind in the low bits, delay flag on top
   localparam int BRC_W       = 3;
   localparam int BRC_DLY_BIT = 2;
   localparam logic [1:0] BRK_NONE = 2'd0;
   localparam logic [1:0] BRK_ALW  = 2'd1;
   localparam logic [1:0] BRK_BEQ  = 2'd2;
   localparam logic [1:0] BRK_BNE  = 2'd3;

   // Resolved branch from execute
   localparam int BRA_W   = 2;
   localparam int BRA_TKN = 1;
   localparam int BRA_DLY = 0;

endpackage

// File: isa_pkg.sv
// Instruction set encoding
// Opcodes, instruction formats and trap vectors
package isa_pkg;

   // Datapath and register file geometry
   localparam int XLEN     = 32;
   localparam int NUM_REGS = 32;
   localparam int REG_AW   = 5;
   localparam int OPC_W    = 6;

   // One instruction word, two field layouts
   typedef union packed {
      struct packed {
         logic [OPC_W-1:0]  opc;
         logic [REG_AW-1:0] rd;
         logic [REG_AW-1:0] ra;
         logic [REG_AW-1:0] rb;
         logic [10:0]       func;
      } a;
      struct packed {
         logic [OPC_W-1:0]  opc;
         logic [REG_AW-1:0] rd;
         logic [REG_AW-1:0] ra;
         logic [15:0]       imm;
      } b;
   } insn_u;

   // Arithmetic
   localparam logic [OPC_W-1:0] OPC_ADD   = 6'o00;
   localparam logic [OPC_W-1:0] OPC_RSUB  = 6'o01;
   localparam logic [OPC_W-1:0] OPC_ADDI  = 6'o10;
   localparam logic [OPC_W-1:0] OPC_RSUBI = 6'o11;
   // Logic, register form only
   localparam logic [OPC_W-1:0] OPC_OR    = 6'o40;
   localparam logic [OPC_W-1:0] OPC_AND   = 6'o41;
   localparam logic [OPC_W-1:0] OPC_XOR   = 6'o42;
   // Prefix and branches
   localparam logic [OPC_W-1:0] OPC_IMM   = 6'o54;
   localparam logic [OPC_W-1:0] OPC_BRU   = 6'o46;
   localparam logic [OPC_W-1:0] OPC_BRUI  = 6'o56;
   localparam logic [OPC_W-1:0] OPC_BCC   = 6'o47;
   localparam logic [OPC_W-1:0] OPC_BCCI  = 6'o57;

   // Set for every type-B opcode
   localparam int OPC_IFORM = 3;

   // Unconditional branch mode in ra: delay, absolute, link
   localparam int BRU_DLY_BIT = 4;
   localparam int BRU_ABS_BIT = 3;
   localparam int BRU_LNK_BIT = 2;
   localparam logic [REG_AW-1:0] BRU_MODE_AL = 5'b01100;

   // Conditional branch mode in rd, ra names the tested register
   localparam int BCC_DLY_BIT = 4;
   localparam int BCC_NE_BIT  = 0;

   // Forced branch-link, absolute, no delay slot
   localparam logic [XLEN-1:0] INSN_INT = {OPC_BRUI, 5'd14, BRU_MODE_AL, 16'h0010};
   localparam logic [XLEN-1:0] INSN_XCE = {OPC_BRUI, 5'd17, BRU_MODE_AL, 16'h0020};

endpackage
